/* dv/gold_miner_rope_tb.sv */
// Rope subsystem testbench
`timescale 1ns/1ps

module gold_miner_rope_tb;

    localparam int TIMEOUT = 20000;

    logic                   clock;
    logic                   resetn;
    logic                   enable;
    logic                   go_key;
    logic                   load_we;
    item_pkg::item_idx_t    load_index;
    item_pkg::item_rec_t    load_item;
    logic [4:0]             item_count;
    logic                   draw_busy;
    item_pkg::item_idx_t    draw_index;
    item_pkg::item_rec_t    draw_item;
    rope_geom_pkg::angle_t  angle;
    rope_geom_pkg::length_t length;
    rope_geom_pkg::tip_t    tip;
    item_pkg::score_t       score;

    integer seed;
    int     errors;
    int     timeouts;
    int     busy_mode;
    bit     watch_len;
    bit     watch_drop;
    bit     watch_carry;
    bit     exp_known;
    item_pkg::item_rec_t exp_rec;
    int     peak_len;
    int     peak_y;
    bit     db_d1;
    bit     db_d2;
    int     len_d1;
    int     len_d2;
    int     fd;
    int     nread;
    int     c_kind;
    int     c_x;
    int     c_y;
    int     c_score;
    string  line;

    gold_miner_rope #(
        .FRAME_CYCLES (4)
    ) u_gold_miner_rope (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .go_key     (go_key),
        .load_we    (load_we),
        .load_index (load_index),
        .load_item  (load_item),
        .item_count (item_count),
        .draw_busy  (draw_busy),
        .draw_index (draw_index),
        .draw_item  (draw_item),
        .angle      (angle),
        .length     (length),
        .tip        (tip),
        .score      (score)
    );

    always #20 clock = ~clock;

    // renderer activity: 0 idle, 1 random, 2 always busy
    always @(posedge clock) begin
        if (busy_mode == 1) begin
            draw_busy <= ($random(seed) & 1) != 0;
        end else begin
            draw_busy <= (busy_mode == 2);
        end
    end

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t %s actual=%0d expected=%0d",
                     $time, name, actual, expected);
            errors++;
        end
    endtask

    // draw_item at a falling edge reflects the address of the cycle before
    always @(negedge clock) begin
        if (watch_len && int'(length) != len_d1) begin
            check_value("length_step", (int'(length) > len_d1) ? int'(length) - len_d1
                                                                : len_d1 - int'(length), 6);
        end
        if (watch_len && int'(length) > peak_len) begin
            peak_len = length;
        end
        if (watch_len && int'(tip.y) > peak_y) begin
            peak_y = tip.y;
        end
        if (watch_drop) begin
            check_value("angle", angle, 90);
        end
        // straight down the tip sits at the origin x, length below the origin
        if (watch_drop && len_d1 == int'(length)) begin
            check_value("tip_x", tip.x, 160);
            check_value("tip_y", tip.y, 45 + int'(length));
        end
        if (db_d1 && exp_known) begin
            check_value("draw_item", draw_item, exp_rec);
        end
        // carried item follows the straight-down tip once the last write has gone through
        if (watch_carry && db_d1 && !db_d2 && len_d1 == int'(length)
                && len_d2 == int'(length) && int'(length) < peak_len && draw_item.held) begin
            check_value("carry_pos_x", draw_item.pos_x, 160 - 4);
            check_value("carry_pos_y", draw_item.pos_y, 45 + int'(length) - 4);
        end
        db_d2  = db_d1;
        db_d1  = draw_busy;
        len_d2 = len_d1;
        len_d1 = length;
    end

    task automatic set_busy_mode(input int mode);
        @(negedge clock);
        busy_mode = mode;
    endtask

    task automatic wait_length(input bit above, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while ((above ? (length <= 20) : (length != 20)) && n < TIMEOUT);
        if (n >= TIMEOUT) begin
            $display("ERROR: timed out waiting for the rope to %s", what);
            timeouts++;
        end
    endtask

    task automatic stop_rope();
        int n;
        int stable;
        int prev;
        @(posedge clock);
        enable <= 1'b0;
        set_busy_mode(0);
        n = 0;
        stable = 0;
        prev = angle;
        while (stable < 24 && n < TIMEOUT) begin
            @(negedge clock);
            n++;
            stable = (int'(angle) == prev && length == 20) ? stable + 1 : 0;
            prev = angle;
        end
        if (n >= TIMEOUT) begin
            $display("ERROR: timed out waiting for the rope to stop");
            timeouts++;
        end
        check_value("stopped_angle", angle, 90);
    endtask

    task automatic wait_swing_resume();
        int n;
        n = 0;
        while (int'(angle) == 90 && n < TIMEOUT) begin
            @(negedge clock);
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("ERROR: timed out waiting for the swing to resume");
            timeouts++;
        end
    endtask

    task automatic press_go_and_enable();
        @(posedge clock);
        go_key <= 1'b1;
        @(posedge clock);
        go_key <= 1'b0;
        @(posedge clock);
        enable <= 1'b1;
        peak_len = 20;
        peak_y = 0;
        watch_len = 1'b1;
        watch_drop = 1'b1;
    endtask

    // straight drop: returns the length where the rope hits or leaves the field
    function automatic int drop_peak(input int x, input int y, output bit hit);
        int len;
        int ty;
        hit = 1'b0;
        len = 26;
        ty = 45 + len;
        while (ty < 238) begin
            if (x < 160 && 160 <= x + 16 && y - 6 < ty && ty <= y + 16) begin
                hit = 1'b1;
                return len;
            end
            len += 6;
            ty = 45 + len;
        end
        return len;
    endfunction

    task automatic read_slot();
        set_busy_mode(2);
        repeat (3) @(posedge clock);
        @(negedge clock);
        check_value("slot_record", draw_item, exp_rec);
        set_busy_mode(0);
    endtask

    task automatic run_case(input int kind, input int x, input int y, input int exp_score);
        item_pkg::item_rec_t rec;
        bit will_hit;
        int exp_peak;
        stop_rope();
        exp_known = 1'b0;
        rec.pos_x   = 9'(x);
        rec.pos_y   = 8'(y);
        rec.kind    = item_pkg::item_kind_e'(kind);
        rec.visible = 1'b1;
        rec.held    = 1'b0;
        @(posedge clock);
        load_we    <= 1'b1;
        load_index <= '0;
        load_item  <= rec;
        item_count <= 5'd1;
        @(posedge clock);
        load_we <= 1'b0;
        exp_peak = drop_peak(x, y, will_hit);
        exp_rec = rec;
        exp_known = !will_hit;
        watch_carry = will_hit;
        press_go_and_enable();
        set_busy_mode(1);
        wait_length(1'b1, "drop");
        wait_length(1'b0, "return to minimum length");
        watch_drop = 1'b0;
        set_busy_mode(0);
        repeat (4) @(posedge clock);
        watch_len = 1'b0;
        watch_carry = 1'b0;
        @(negedge clock);
        check_value("score", score, exp_score);
        check_value("peak_length", peak_len, exp_peak);
        if (will_hit) begin
            exp_rec.pos_x   = 9'd156;
            exp_rec.pos_y   = 8'd61;
            exp_rec.visible = 1'b0;
            exp_rec.held    = 1'b0;
        end
        read_slot();
        exp_known = 1'b1;
    endtask

    task automatic check_swing();
        int n;
        int prev;
        int dir;
        int new_dir;
        int reversals;
        int after;
        n = 0;
        dir = 0;
        reversals = 0;
        after = 0;
        prev = angle;
        @(posedge clock);
        enable <= 1'b1;
        while ((reversals == 0 || after < 5) && n < TIMEOUT) begin
            @(negedge clock);
            n++;
            if (int'(angle) != prev) begin
                new_dir = int'(angle) - prev;
                check_value("angle_change", (new_dir < 0) ? -new_dir : new_dir, 1);
                check_value("angle_in_range", (angle >= 15 && angle <= 165), 1);
                if (dir != 0 && new_dir != dir) begin
                    reversals++;
                    // the turn point is the limit the rope was heading for
                    check_value("reversal_angle", prev, (new_dir > 0) ? 15 : 165);
                end
                after = (reversals > 0) ? after + 1 : 0;
                dir = new_dir;
                prev = angle;
            end
        end
        if (n >= TIMEOUT) begin
            $display("ERROR: timed out waiting for the swing to reverse");
            timeouts++;
        end
    endtask

    initial begin
        clock = 1'b0;
        resetn = 1'b0;
        enable = 1'b0;
        go_key = 1'b0;
        load_we = 1'b0;
        load_index = '0;
        load_item = '0;
        item_count = '0;
        draw_busy = 1'b0;
        draw_index = '0;
        seed = 76036;
        errors = 0;
        timeouts = 0;
        busy_mode = 0;
        watch_len = 1'b0;
        watch_drop = 1'b0;
        watch_carry = 1'b0;
        exp_known = 1'b0;
        exp_rec = '0;
        db_d1 = 1'b0;
        db_d2 = 1'b0;
        len_d1 = 20;
        len_d2 = 20;
        repeat (2) @(posedge clock);
        resetn <= 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        check_value("angle", angle, 90);
        check_value("length", length, 20);
        check_value("score", score, 0);
        check_value("tip_x", tip.x, 160);
        check_value("tip_y", tip.y, 65);

        check_swing();

        // empty drop, nothing in the table
        stop_rope();
        press_go_and_enable();
        set_busy_mode(1);
        wait_length(1'b1, "drop");
        wait_length(1'b0, "return to minimum length");
        watch_drop = 1'b0;
        set_busy_mode(0);
        watch_len = 1'b0;
        check_value("score", score, 0);
        check_value("peak_tip_y_reached", peak_y >= 238, 1);
        wait_swing_resume();

        fd = $fopen("dv/rope_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the case file dv/rope_cases.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    nread = $sscanf(line, "%d %d %d %d", c_kind, c_x, c_y, c_score);
                    if (nread == 4) begin
                        run_case(c_kind, c_x, c_y, c_score);
                    end
                end
            end
            $fclose(fd);
        end

        $display("run finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* dv/rope_cases.txt */
# kind (0 stone, 1 gold, 2 diamond), item x, item y, expected score after the drop
# all values decimal, one case per line
1 150 100 20
0 144 120 10
2 159 200 50
1 170 100 0
0 143 150 0
2 160 150 0
1 152 40 0
0 148 230 10
2 150 250 0
1 155 60 20
2 140 180 0
0 158 210 10
2 146 90 50

/* gold_miner_rope.f */
rtl/rope_geom_pkg.sv
rtl/item_pkg.sv
rtl/frame_tick.sv
rtl/trig_lut.sv
rtl/item_store.sv
rtl/score_counter.sv
rtl/rope_controller.sv
rtl/gold_miner_rope.sv
dv/gold_miner_rope_tb.sv

/* rtl/frame_tick.sv */
// Frame step pulse generator
`timescale 1ns/1ps

module frame_tick #(
    parameter int FRAME_CYCLES = 833334
) (
    input  logic clock,
    input  logic resetn,
    input  logic run,
    output logic step
);

    logic [$clog2(FRAME_CYCLES)-1:0] count;

    // restarts from zero whenever the rope is stopped
    always_ff @(posedge clock) begin
        if (!resetn || !run) begin
            count <= '0;
            step  <= 1'b0;
        end else if (count == FRAME_CYCLES - 1) begin
            count <= '0;
            step  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            step  <= 1'b0;
        end
    end

endmodule

/* rtl/gold_miner_rope.sv */
// Claw game rope subsystem top
`timescale 1ns/1ps

module gold_miner_rope #(
    parameter int FRAME_CYCLES = 833334
) (
    input  logic                   clock,
    input  logic                   resetn,
    input  logic                   enable,
    input  logic                   go_key,
    input  logic                   load_we,
    input  item_pkg::item_idx_t    load_index,
    input  item_pkg::item_rec_t    load_item,
    input  logic [4:0]             item_count,
    input  logic                   draw_busy,
    input  item_pkg::item_idx_t    draw_index,
    output item_pkg::item_rec_t    draw_item,
    output rope_geom_pkg::angle_t  angle,
    output rope_geom_pkg::length_t length,
    output rope_geom_pkg::tip_t    tip,
    output item_pkg::score_t       score
);

    logic                step;
    logic                run;
    item_pkg::item_idx_t rope_index;
    logic                rope_we;
    item_pkg::item_rec_t rope_wdata;
    item_pkg::item_rec_t rd_item;
    logic                add_en;
    item_pkg::score_t    add_value;

    frame_tick #(
        .FRAME_CYCLES (FRAME_CYCLES)
    ) u_frame_tick (
        .clock  (clock),
        .resetn (resetn),
        .run    (run),
        .step   (step)
    );

    item_store u_item_store (
        .clock      (clock),
        .load_we    (load_we),
        .load_index (load_index),
        .load_item  (load_item),
        .draw_busy  (draw_busy),
        .draw_index (draw_index),
        .rope_index (rope_index),
        .rope_we    (rope_we),
        .rope_wdata (rope_wdata),
        .rd_item    (rd_item)
    );

    // a level load starts a new score
    score_counter u_score_counter (
        .clock     (clock),
        .resetn    (resetn),
        .clear     (load_we),
        .add_en    (add_en),
        .add_value (add_value),
        .score     (score)
    );

    rope_controller u_rope_controller (
        .clock      (clock),
        .resetn     (resetn),
        .enable     (enable),
        .go_key     (go_key),
        .draw_busy  (draw_busy),
        .step       (step),
        .item_count (item_count),
        .rd_item    (rd_item),
        .run        (run),
        .angle      (angle),
        .length     (length),
        .tip        (tip),
        .rope_index (rope_index),
        .rope_we    (rope_we),
        .rope_wdata (rope_wdata),
        .add_en     (add_en),
        .add_value  (add_value)
    );

    assign draw_item = rd_item;

endmodule

/* rtl/item_pkg.sv */
// Item record definitions
package item_pkg;

    typedef logic [3:0] item_idx_t;

    typedef enum logic [1:0] {
        STONE,
        GOLD,
        DIAMOND
    } item_kind_e;

    typedef struct packed {
        logic [8:0] pos_x;
        logic [7:0] pos_y;
        item_kind_e kind;
        logic       visible;
        logic       held;
    } item_rec_t;

    typedef logic [9:0] score_t;

    localparam int ITEM_SLOTS   = 16;
    localparam int ITEM_SIZE    = 16;
    // hit box starts a little above the item
    localparam int HIT_Y_MARGIN = 6;

    localparam score_t SCORE_STONE   = 10'd10;
    localparam score_t SCORE_GOLD    = 10'd20;
    localparam score_t SCORE_DIAMOND = 10'd50;

endpackage

/* rtl/item_store.sv */
// Item record memory
`timescale 1ns/1ps

module item_store (
    input  logic                clock,
    input  logic                load_we,
    input  item_pkg::item_idx_t load_index,
    input  item_pkg::item_rec_t load_item,
    input  logic                draw_busy,
    input  item_pkg::item_idx_t draw_index,
    input  item_pkg::item_idx_t rope_index,
    input  logic                rope_we,
    input  item_pkg::item_rec_t rope_wdata,
    output item_pkg::item_rec_t rd_item
);

    item_pkg::item_rec_t mem [item_pkg::ITEM_SLOTS];

    item_pkg::item_idx_t addr;
    item_pkg::item_rec_t wdata;
    logic                we;

    // loader first, then renderer, then rope
    always_comb begin
        if (load_we) begin
            addr  = load_index;
            wdata = load_item;
            we    = 1'b1;
        end else if (draw_busy) begin
            addr  = draw_index;
            wdata = rope_wdata;
            we    = 1'b0;
        end else begin
            addr  = rope_index;
            wdata = rope_wdata;
            we    = rope_we;
        end
    end

    always_ff @(posedge clock) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rd_item <= mem[addr];
    end

endmodule

/* rtl/rope_controller.sv */
// Rope swing, drop and capture controller
`timescale 1ns/1ps

module rope_controller (
    input  logic                   clock,
    input  logic                   resetn,
    input  logic                   enable,
    input  logic                   go_key,
    input  logic                   draw_busy,
    input  logic                   step,
    input  logic [4:0]             item_count,
    input  item_pkg::item_rec_t    rd_item,
    output logic                   run,
    output rope_geom_pkg::angle_t  angle,
    output rope_geom_pkg::length_t length,
    output rope_geom_pkg::tip_t    tip,
    output item_pkg::item_idx_t    rope_index,
    output logic                   rope_we,
    output item_pkg::item_rec_t    rope_wdata,
    output logic                   add_en,
    output item_pkg::score_t       add_value
);

    typedef enum logic [2:0] {
        STOP,
        SWING,
        DROP,
        SCAN_ADDR,
        SCAN_CHECK,
        RETRACT,
        CARRY_WRITE,
        COLLECT
    } state_e;

    state_e              state;
    logic                dir_up;
    logic                go_prev;
    logic                go_pend;
    logic                step_pend;
    logic                held;
    logic [4:0]          slot_idx;
    logic [2:0]          wait_cnt;
    item_pkg::item_rec_t wrec;

    rope_geom_pkg::trig_t   trig;
    rope_geom_pkg::tip_t    tip_now;
    logic [18:0]            prod_x;
    logic [18:0]            prod_y;
    logic [10:0]            tx;
    logic [10:0]            ty;
    logic [10:0]            px;
    logic [10:0]            py;
    logic                   step_seen;
    logic                   consume;
    logic                   out_of_field;
    logic                   hit;
    logic                   scan_hit;
    logic                   wait_done;
    rope_geom_pkg::length_t len_up;
    rope_geom_pkg::length_t len_dn;

    trig_lut u_trig_lut (
        .angle (angle),
        .trig  (trig)
    );

    // tip position from the current angle and length
    always_comb begin
        prod_x = length * trig.cos_mag;
        prod_y = length * trig.sin_mag;
        if (trig.cos_neg) begin
            tip_now.x = rope_geom_pkg::coord_t'(rope_geom_pkg::ORIGIN_X - prod_x[18:8]);
        end else begin
            tip_now.x = rope_geom_pkg::coord_t'(rope_geom_pkg::ORIGIN_X + prod_x[18:8]);
        end
        tip_now.y = rope_geom_pkg::coord_t'(rope_geom_pkg::ORIGIN_Y + prod_y[18:8]);
    end

    assign out_of_field = (tip_now.x < rope_geom_pkg::FIELD_X_LO)
                       || (tip_now.x >= rope_geom_pkg::FIELD_X_HI)
                       || (tip_now.y >= rope_geom_pkg::FIELD_Y_HI);

    // item box test, margin moved to the tip side to avoid underflow
    assign tx  = {1'b0, tip_now.x};
    assign ty  = {1'b0, tip_now.y};
    assign px  = {2'b0, rd_item.pos_x};
    assign py  = {3'b0, rd_item.pos_y};
    assign hit = rd_item.visible && !rd_item.held
              && (px < tx) && (tx <= px + 11'(item_pkg::ITEM_SIZE))
              && (py < ty + 11'(item_pkg::HIT_Y_MARGIN))
              && (ty <= py + 11'(item_pkg::ITEM_SIZE));

    assign scan_hit = (state == SCAN_CHECK) && !out_of_field && (slot_idx < item_count) && hit;

    // a step seen during draw_busy waits until it falls
    assign step_seen = step || step_pend;
    assign consume   = step_seen && !draw_busy
                    && ((state == SWING) || (state == DROP) || (state == RETRACT));
    assign wait_done = (wait_cnt == (held ? rope_geom_pkg::UP_WAIT_HELD
                                          : rope_geom_pkg::UP_WAIT_EMPTY) - 3'd1);

    assign len_up = length + rope_geom_pkg::ROPE_STEP;
    assign len_dn = (length <= rope_geom_pkg::ROPE_MIN + rope_geom_pkg::ROPE_STEP)
                  ? rope_geom_pkg::ROPE_MIN : length - rope_geom_pkg::ROPE_STEP;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state     <= STOP;
            angle     <= rope_geom_pkg::ANGLE_START;
            length    <= rope_geom_pkg::ROPE_MIN;
            dir_up    <= 1'b0;
            go_prev   <= 1'b0;
            go_pend   <= 1'b0;
            step_pend <= 1'b0;
            held      <= 1'b0;
            slot_idx  <= '0;
            wait_cnt  <= '0;
        end else begin
            go_prev   <= go_key;
            step_pend <= step_seen && !consume && (state != STOP);
            if (go_key && !go_prev) begin
                go_pend <= 1'b1;
            end
            case (state)
                STOP: begin
                    angle  <= rope_geom_pkg::ANGLE_START;
                    length <= rope_geom_pkg::ROPE_MIN;
                    dir_up <= 1'b0;
                    held   <= 1'b0;
                    if (enable) begin
                        state <= SWING;
                    end
                end
                SWING: begin
                    if (consume) begin
                        if (!enable) begin
                            state   <= STOP;
                            go_pend <= 1'b0;
                        end else if (go_pend) begin
                            state   <= DROP;
                            go_pend <= 1'b0;
                        end else if (dir_up) begin
                            angle <= angle + 10'd1;
                            if (angle >= rope_geom_pkg::ANGLE_MAX - 10'd1) begin
                                dir_up <= 1'b0;
                            end
                        end else begin
                            angle <= angle - 10'd1;
                            if (angle <= rope_geom_pkg::ANGLE_MIN + 10'd1) begin
                                dir_up <= 1'b1;
                            end
                        end
                    end
                end
                DROP: begin
                    if (consume) begin
                        length   <= len_up;
                        slot_idx <= '0;
                        state    <= SCAN_ADDR;
                    end
                end
                // read only while the renderer is idle
                SCAN_ADDR: begin
                    if (!draw_busy) begin
                        state <= SCAN_CHECK;
                    end
                end
                SCAN_CHECK: begin
                    wait_cnt <= '0;
                    if (out_of_field) begin
                        state <= RETRACT;
                    end else if (slot_idx >= item_count) begin
                        state <= DROP;
                    end else if (hit) begin
                        state <= CARRY_WRITE;
                    end else begin
                        slot_idx <= slot_idx + 5'd1;
                        state    <= SCAN_ADDR;
                    end
                end
                RETRACT: begin
                    if (consume && wait_done) begin
                        wait_cnt <= '0;
                        length   <= len_dn;
                        if (held) begin
                            state <= (len_dn == rope_geom_pkg::ROPE_MIN) ? COLLECT : CARRY_WRITE;
                        end else if (len_dn == rope_geom_pkg::ROPE_MIN) begin
                            state <= SWING;
                        end
                    end else if (consume) begin
                        wait_cnt <= wait_cnt + 3'd1;
                    end
                end
                CARRY_WRITE: begin
                    if (!draw_busy) begin
                        held  <= 1'b1;
                        state <= RETRACT;
                    end
                end
                COLLECT: begin
                    if (!draw_busy) begin
                        held  <= 1'b0;
                        state <= SWING;
                    end
                end
                default: state <= STOP;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        tip <= tip_now;
        if (scan_hit) begin
            wrec <= rd_item;
        end
    end

    // first write only marks the record held, later ones follow the tip
    always_comb begin
        rope_wdata      = wrec;
        rope_wdata.held = 1'b1;
        if (held) begin
            rope_wdata.pos_x = 9'(tip_now.x - 10'd4);
            rope_wdata.pos_y = 8'(tip_now.y - 10'd4);
        end
        if (state == COLLECT) begin
            rope_wdata.visible = 1'b0;
            rope_wdata.held    = 1'b0;
        end
    end

    always_comb begin
        case (wrec.kind)
            item_pkg::STONE: add_value = item_pkg::SCORE_STONE;
            item_pkg::GOLD:  add_value = item_pkg::SCORE_GOLD;
            default:         add_value = item_pkg::SCORE_DIAMOND;
        endcase
    end

    assign run        = (state != STOP);
    assign rope_index = slot_idx[3:0];
    assign rope_we    = ((state == CARRY_WRITE) || (state == COLLECT)) && !draw_busy;
    assign add_en     = (state == COLLECT) && !draw_busy;

endmodule

/* rtl/rope_geom_pkg.sv */
// Rope geometry definitions
package rope_geom_pkg;

    typedef logic [9:0] angle_t;
    typedef logic [9:0] coord_t;
    typedef logic [9:0] length_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } tip_t;

    // magnitudes scaled so that 256 is 1.0
    typedef struct packed {
        logic [8:0] sin_mag;
        logic [8:0] cos_mag;
        logic       cos_neg;
    } trig_t;

    localparam coord_t ORIGIN_X = 10'd160;
    localparam coord_t ORIGIN_Y = 10'd45;

    localparam angle_t ANGLE_START = 10'd90;
    localparam angle_t ANGLE_MIN   = 10'd15;
    localparam angle_t ANGLE_MAX   = 10'd165;

    localparam length_t ROPE_MIN  = 10'd20;
    localparam length_t ROPE_STEP = 10'd6;

    localparam coord_t FIELD_X_LO = 10'd2;
    localparam coord_t FIELD_X_HI = 10'd318;
    localparam coord_t FIELD_Y_HI = 10'd238;

    // frame steps per retraction step
    localparam logic [2:0] UP_WAIT_EMPTY = 3'd2;
    localparam logic [2:0] UP_WAIT_HELD  = 3'd5;

endpackage

/* rtl/score_counter.sv */
// Captured item score accumulator
`timescale 1ns/1ps

module score_counter (
    input  logic             clock,
    input  logic             resetn,
    input  logic             clear,
    input  logic             add_en,
    input  item_pkg::score_t add_value,
    output item_pkg::score_t score
);

    // one extra bit to catch overflow
    logic [10:0] sum;

    assign sum = {1'b0, score} + {1'b0, add_value};

    always_ff @(posedge clock) begin
        if (!resetn) begin
            score <= '0;
        end else if (clear) begin
            score <= '0;
        end else if (add_en) begin
            score <= sum[10] ? '1 : sum[9:0];
        end
    end

endmodule

/* rtl/trig_lut.sv */
// Sine and cosine table
`timescale 1ns/1ps

module trig_lut (
    input  rope_geom_pkg::angle_t angle,
    output rope_geom_pkg::trig_t  trig
);

    // round(256 * sin(d)) for d = 0 to 90
    localparam logic [8:0] SIN_TAB [0:90] = '{
        9'd0,   9'd4,   9'd9,   9'd13,  9'd18,  9'd22,  9'd27,  9'd31,  9'd36,  9'd40,
        9'd44,  9'd49,  9'd53,  9'd58,  9'd62,  9'd66,  9'd71,  9'd75,  9'd79,  9'd83,
        9'd88,  9'd92,  9'd96,  9'd100, 9'd104, 9'd108, 9'd112, 9'd116, 9'd120, 9'd124,
        9'd128, 9'd132, 9'd136, 9'd139, 9'd143, 9'd147, 9'd150, 9'd154, 9'd158, 9'd161,
        9'd165, 9'd168, 9'd171, 9'd175, 9'd178, 9'd181, 9'd184, 9'd187, 9'd190, 9'd193,
        9'd196, 9'd199, 9'd202, 9'd204, 9'd207, 9'd210, 9'd212, 9'd215, 9'd217, 9'd219,
        9'd222, 9'd224, 9'd226, 9'd228, 9'd230, 9'd232, 9'd234, 9'd236, 9'd237, 9'd239,
        9'd241, 9'd242, 9'd243, 9'd245, 9'd246, 9'd247, 9'd248, 9'd249, 9'd250, 9'd251,
        9'd252, 9'd253, 9'd254, 9'd254, 9'd255, 9'd255, 9'd255, 9'd256, 9'd256, 9'd256,
        9'd256
    };

    // angle folded into the first quadrant
    logic [6:0] fold;

    always_comb begin
        if (angle <= 10'd90) begin
            fold = angle[6:0];
        end else if (angle <= 10'd180) begin
            fold = 7'(10'd180 - angle);
        end else begin
            fold = 7'd0;
        end
        trig.sin_mag = SIN_TAB[fold];
        // cos(d) = sin(90 - d)
        trig.cos_mag = SIN_TAB[7'd90 - fold];
        trig.cos_neg = (angle > 10'd90);
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the rope subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module gold_miner_rope_tb \
    -f gold_miner_rope.f -o sim_rope
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/sim_rope)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with an error status"
    exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1
